//--- gb_io.f
hdl/gb_map_pkg.sv
hdl/gb_irq_pkg.sv
hdl/io_decode.sv
hdl/joypad_port.sv
hdl/serial_link.sv
hdl/irq_ctrl.sv
hdl/hram.sv
hdl/read_return.sv
hdl/gb_io_top.sv
sim/gb_io_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= gb_io_tb
RTL_TOP    ?= gb_io_top
FILELIST   ?= gb_io.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q -F '** FAIL **' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q -F '** PASS **' $(LOG); then echo "no result in $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/gb_io_tb.sv
// io register block testbench with reads checked in issue order against a shadow model
// hram is filled before any read since its power up contents are undefined
// joypad edge delay and serial length are not fixed and are waited out or polled
// inputs change on the rising edge and outputs are sampled on the falling edge
module gb_io_tb import gb_map_pkg::*, gb_irq_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int serial_len = serial_bits * serial_bit_cycles;
	localparam int max_cycles = (serial_len + 900) * 4;	// serial test dominates

	logic      clk_cpu, reset;
	bus_addr_t cpu_addr;
	bus_data_t cpu_wdata, cpu_rdata, joystick, irq_vec;
	logic      cpu_wr, cpu_rd, vblank_evt, lcd_evt, timer_evt, irq_ack;
	logic      rd_valid, irq_n;

	// --------------------
	// shadow model
	bus_data_t  hram_m [hram_depth];
	irq_mask_t  if_m, ie_m;
	logic [1:0] p1_sel_m;		// P1 bits 5:4
	logic       sc_busy_m, sc_clk_m;
	bus_data_t  joy_m;		// joystick as driven

	logic [31:0] lfsr = 32'h6be3;	// seed
	bus_data_t exp_q[$];		// outstanding reads
	bus_addr_t addr_q[$];
	bit        chk_q[$];		// 0 for polls whose result is not predicted
	int        issue_q[$];		// falling edge count at each read strobe
	int        neg_cnt = 0;		// falling edges seen so far
	int rdata_errs = 0, vec_errs = 0, irqn_errs = 0, misc_errs = 0;
	int cycle_cnt = 0;

	gb_io_top uut (
		.clk_cpu, .reset, .cpu_addr, .cpu_wdata, .cpu_wr, .cpu_rd, .joystick,
		.vblank_evt, .lcd_evt, .timer_evt, .irq_ack,
		.cpu_rdata, .rd_valid, .irq_n, .irq_vec
	);

	initial begin
		clk_cpu = 1'b0;
		forever #50 clk_cpu = ~clk_cpu;	// 100 ns
	end

	// galois form with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);	// one step per bit
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// expected read byte from the shadow state
	function automatic bus_data_t expected_read(bus_addr_t a);
		logic [3:0] dir, btn;
		dir = 4'hf;
		btn = 4'hf;
		if (!p1_sel_m[0]) begin	// direction group in right left up down order
			dir[0] = ~joy_m[0];
			dir[1] = ~joy_m[1];
			dir[3] = ~joy_m[2];
			dir[2] = ~joy_m[3];
		end
		if (!p1_sel_m[1])
			btn = ~joy_m[7:4];
		if (a == 16'hffff)
			return {3'b000, ie_m};
		if (a >= 16'hff80)
			return hram_m[7'(a - 16'hff80)];
		case (a)
			16'hff00: return {2'b11, p1_sel_m, dir & btn};
			16'hff02: return {sc_busy_m, 6'h3f, sc_clk_m};
			16'hff0f: return {3'b111, if_m};
			default:  return 8'hff;	// SB and unmapped
		endcase
	endfunction

	function automatic bus_data_t expected_vector(irq_mask_t m);
		bus_data_t v;
		v = 8'h55;
		for (int i = 0; i < 5; i++)
			if (m[i] && v == 8'h55)
				v = 8'h40 + 8'(i * 8);	// first hit wins
		return v;
	endfunction

	task automatic check_rdata(bus_addr_t a, bus_data_t got, bus_data_t exp);
		if (got !== exp) begin
			rdata_errs++;
			$display("CHECK FAILED cpu_rdata addr %h: got %h expected %h", a, got, exp);
		end
	endtask

	task automatic check_vector(bus_data_t got, bus_data_t exp);
		if (got !== exp) begin
			vec_errs++;
			$display("CHECK FAILED irq_vec: got %h expected %h", got, exp);
		end
	endtask

	task automatic check_irq_n(logic got, logic exp);
		if (got !== exp) begin
			irqn_errs++;
			$display("CHECK FAILED irq_n: got %h expected %h", got, exp);
		end
	endtask

	task automatic print_counts();
		$display("errors: cpu_rdata %0d, irq_vec %0d, irq_n %0d, other %0d",
			rdata_errs, vec_errs, irqn_errs, misc_errs);
	endtask

	// --------------------
	// bus and event drivers that set every strobe on each edge
	task automatic drive_strobes(logic wr, logic rd, logic [2:0] evt, logic ack);
		@(posedge clk_cpu);
		cpu_wr     <= wr;
		cpu_rd     <= rd;
		vblank_evt <= evt[0];
		lcd_evt    <= evt[1];
		timer_evt  <= evt[2];
		irq_ack    <= ack;
	endtask

	task automatic bus_idle(int n);
		repeat (n) drive_strobes(1'b0, 1'b0, 3'b000, 1'b0);
	endtask

	task automatic bus_write(bus_addr_t a, bus_data_t d);
		drive_strobes(1'b1, 1'b0, 3'b000, 1'b0);
		cpu_addr  <= a;
		cpu_wdata <= d;
		if (a == 16'hffff)
			ie_m = d[4:0];
		else if (a >= 16'hff80)
			hram_m[7'(a - 16'hff80)] = d;
		else if (a == 16'hff00)
			p1_sel_m = d[5:4];
		else if (a == 16'hff0f)
			if_m = d[4:0];
		else if (a == 16'hff02) begin
			sc_busy_m = d[7];
			sc_clk_m  = d[0];
		end
	endtask

	task automatic bus_read(bus_addr_t a, bit chk);
		drive_strobes(1'b0, 1'b1, 3'b000, 1'b0);
		cpu_addr <= a;
		exp_q.push_back(expected_read(a));
		addr_q.push_back(a);
		chk_q.push_back(chk);
		issue_q.push_back(neg_cnt);
	endtask

	// unpredicted read that returns the byte itself
	task automatic read_now(bus_addr_t a, output bus_data_t d);
		bus_read(a, 1'b0);
		bus_idle(1);
		do
			@(negedge clk_cpu);
		while (rd_valid !== 1'b1);
		d = cpu_rdata;
	endtask

	task automatic pulse_event(int src);
		drive_strobes(1'b0, 1'b0, 3'(1 << src), 1'b0);
		if_m[src] = 1'b1;
	endtask

	task automatic ack_irq();
		irq_mask_t p;
		logic done;
		p = if_m & ie_m;
		done = 1'b0;
		drive_strobes(1'b0, 1'b0, 3'b000, 1'b1);
		for (int i = 0; i < 5; i++)
			if (p[i] && !done) begin	// lowest pending only
				if_m[i] = 1'b0;
				done = 1'b1;
			end
	endtask

	task automatic set_joystick(bus_data_t v);
		drive_strobes(1'b0, 1'b0, 3'b000, 1'b0);
		joystick <= v;
		joy_m = v;
	endtask

	task automatic check_irq_lines();
		@(negedge clk_cpu);
		check_vector(irq_vec, expected_vector(if_m & ie_m));
		check_irq_n(irq_n, ~|(if_m & ie_m));
	endtask

	// read data and latency compare in issue order
	always @(negedge clk_cpu) begin : compare_reads
		bus_data_t e;
		bus_addr_t a;
		bit c;
		int t;
		if (rd_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				misc_errs++;
				$display("rd_valid was high with no read outstanding");
			end else begin
				e = exp_q.pop_front();
				a = addr_q.pop_front();
				c = chk_q.pop_front();
				t = issue_q.pop_front();
				if (neg_cnt - t != 2) begin
					misc_errs++;
					$display("read of %h returned %0d cycles after its strobe instead of 2",
						a, neg_cnt - t);
				end
				if (c)
					check_rdata(a, cpu_rdata, e);
			end
		end
		neg_cnt++;
	end

	initial begin
		while (cycle_cnt < max_cycles) begin
			@(posedge clk_cpu);
			cycle_cnt++;
		end
		$display("timeout, run stopped after %0d cycles", cycle_cnt);
		print_counts();
		$display("** FAIL **");
		$finish;
	end

	initial begin
		bus_data_t d;
		hram_addr_t o;
		reset = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_wr = 1'b0;
		cpu_rd = 1'b0;
		joystick = '0;
		vblank_evt = 1'b0;
		lcd_evt = 1'b0;
		timer_evt = 1'b0;
		irq_ack = 1'b0;
		if_m = '0;
		ie_m = '0;
		p1_sel_m = '0;
		sc_busy_m = 1'b0;
		sc_clk_m = 1'b0;
		joy_m = '0;
		repeat (10) @(posedge clk_cpu);
		reset <= 1'b0;
		bus_idle(2);

		// reset state of the irq lines and registers
		check_irq_lines();
		bus_read(16'hff0f, 1'b1);
		bus_read(16'hffff, 1'b1);
		bus_read(16'hff02, 1'b1);
		bus_read(16'hff00, 1'b1);

		// --------------------
		// hram fill, random back to back traffic, then IE at ffff
		for (int i = 0; i < hram_depth; i++)
			bus_write(16'hff80 + 16'(i), 8'(rand_bits(8)));
		for (int i = 0; i < 300; i++) begin
			o = 7'(rand_bits(7));
			if (o == 7'h7f)
				o = 7'h00;	// ffff is not hram
			if (rand_bits(1) == 1)
				bus_write(16'hff80 + 16'(o), 8'(rand_bits(8)));
			else
				bus_read(16'hff80 + 16'(o), 1'b1);
		end
		bus_write(16'hffff, 8'(rand_bits(8)));
		bus_read(16'hffff, 1'b1);
		bus_read(16'hfffe, 1'b1);	// top hram byte untouched
		bus_idle(4);

		// P1 for every select, SB and unmapped
		for (int s = 0; s < 4; s++) begin
			bus_write(16'hff00, 8'(s << 4));
			set_joystick(8'(rand_bits(8)));
			bus_idle(2);
			bus_read(16'hff00, 1'b1);
			bus_idle(1);	// hold joystick past the sample edge
		end
		bus_read(16'hff01, 1'b1);
		bus_read({1'b0, 15'(rand_bits(15))}, 1'b1);
		bus_read(16'hff10, 1'b1);
		set_joystick(8'h00);
		bus_idle(6);	// joypad edges from above settle

		// --------------------
		// event strobes and irq_n
		bus_write(16'hff0f, 8'h00);
		bus_write(16'hffff, 8'h00);
		bus_idle(2);
		pulse_event(irq_vblank);
		bus_idle(2);
		check_irq_lines();	// flagged but not enabled
		bus_read(16'hff0f, 1'b1);
		bus_write(16'hffff, 8'h01);
		bus_idle(2);
		check_irq_lines();
		pulse_event(irq_lcd);
		pulse_event(irq_timer);
		bus_read(16'hff0f, 1'b1);
		bus_idle(2);
		check_irq_lines();

		// priority vector and acknowledge order
		bus_write(16'hff0f, 8'h1f);
		bus_write(16'hffff, 8'h1a);	// lcd serial joypad
		bus_idle(2);
		while ((if_m & ie_m) != '0) begin
			check_irq_lines();
			ack_irq();
			bus_idle(1);
		end
		check_irq_lines();	// none left
		bus_read(16'hff0f, 1'b1);

		// --------------------
		// serial transfer
		bus_write(16'hff0f, 8'h00);
		bus_write(16'hffff, 8'h08);
		bus_write(16'hff02, 8'h81);
		bus_read(16'hff02, 1'b1);
		do begin
			bus_idle(50);
			read_now(16'hff02, d);
		end while (d[7]);
		sc_busy_m = 1'b0;
		if_m[irq_serial] = 1'b1;
		bus_read(16'hff0f, 1'b1);
		bus_read(16'hff02, 1'b1);
		bus_idle(2);
		check_irq_lines();

		// joypad interrupt for the selected then the deselected group
		bus_write(16'hff0f, 8'h00);
		bus_write(16'hffff, 8'h10);
		bus_write(16'hff00, 8'h10);	// buttons only
		bus_idle(2);
		set_joystick(8'(8'h10 << rand_bits(2)));
		bus_idle(8);
		if_m[irq_joypad] = 1'b1;
		bus_read(16'hff0f, 1'b1);
		bus_idle(2);
		check_irq_lines();
		set_joystick(8'h00);
		bus_idle(4);
		bus_write(16'hff0f, 8'h00);
		set_joystick(8'(8'h01 << rand_bits(2)));	// direction in the deselected group
		bus_idle(8);
		bus_read(16'hff0f, 1'b1);
		bus_idle(2);
		check_irq_lines();
		set_joystick(8'h00);

		bus_idle(4);
		while (exp_q.size() != 0)
			@(posedge clk_cpu);
		print_counts();
		if (rdata_errs + vec_errs + irqn_errs + misc_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- hdl/gb_io_top.sv
// io register block of the console, pipelined slave without back-pressure
// read strobe in cycle N returns data with rd_valid in N+2
// a write in cycle N takes effect at the end of N+1
// video, lcd status and timer interrupts enter as one cycle strobes
module gb_io_top import gb_map_pkg::*; (
	input  logic      clk_cpu,
	input  logic      reset,
	input  bus_addr_t cpu_addr,
	input  bus_data_t cpu_wdata,
	input  logic      cpu_wr,
	input  logic      cpu_rd,
	input  bus_data_t joystick,	// 1 is pressed
	input  logic      vblank_evt,
	input  logic      lcd_evt,
	input  logic      timer_evt,
	input  logic      irq_ack,
	output bus_data_t cpu_rdata,
	output logic      rd_valid,
	output logic      irq_n,
	output bus_data_t irq_vec
);

	// stage 1 broadcast
	io_sel_e    sel;
	logic       wr_q, rd_q;
	bus_data_t  wdata_q;
	hram_addr_t hram_addr_q;

	// stage 2 read bytes and events
	bus_data_t joy_rdata, sc_rdata, if_rdata, ie_rdata, hram_rdata;
	logic      joy_edge, serial_evt;

	io_decode u_decode (
		.clk_cpu, .reset, .cpu_addr, .cpu_wdata, .cpu_wr, .cpu_rd,
		.sel, .wr_q, .rd_q, .wdata_q, .hram_addr_q
	);

	// --------------------
	// stage 2 units
	joypad_port u_joy (
		.clk_cpu, .reset, .sel, .wr_q, .wdata_q, .joystick,
		.joy_rdata, .joy_edge
	);

	serial_link u_serial (
		.clk_cpu, .reset, .sel, .wr_q, .wdata_q,
		.sc_rdata, .serial_evt
	);

	irq_ctrl u_irq (
		.clk_cpu, .reset, .sel, .wr_q, .wdata_q,
		.vblank_evt, .lcd_evt, .timer_evt, .serial_evt, .joy_edge, .irq_ack,
		.if_rdata, .ie_rdata, .irq_n, .irq_vec
	);

	hram u_hram (
		.clk_cpu, .sel, .wr_q, .wdata_q, .hram_addr_q,
		.hram_rdata
	);

	read_return u_ret (
		.clk_cpu, .reset, .sel, .rd_q,
		.joy_rdata, .sc_rdata, .if_rdata, .ie_rdata, .hram_rdata,
		.cpu_rdata, .rd_valid
	);

endmodule

//--- hdl/read_return.sv
// third stage, picks the read byte of the addressed unit
// cpu_rdata is only meaningful while rd_valid is high
// SB and unmapped addresses return open bus
module read_return import gb_map_pkg::*; (
	input  logic      clk_cpu,
	input  logic      reset,
	input  io_sel_e   sel,
	input  logic      rd_q,
	input  bus_data_t joy_rdata,
	input  bus_data_t sc_rdata,
	input  bus_data_t if_rdata,
	input  bus_data_t ie_rdata,
	input  bus_data_t hram_rdata,
	output bus_data_t cpu_rdata,
	output logic      rd_valid
);

	io_sel_e sel_q2;	// select, aligned with stage 2 read bytes

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel_q2   <= sel_none;
			rd_valid <= 1'b0;
		end else begin
			sel_q2   <= sel;
			rd_valid <= rd_q;	// two cycles after the strobe
		end
	end

	// --------------------
	// read mux
	always_comb begin
		case (sel_q2)
			sel_joy:  cpu_rdata = joy_rdata;
			sel_sc:   cpu_rdata = sc_rdata;
			sel_if:   cpu_rdata = if_rdata;
			sel_ie:   cpu_rdata = ie_rdata;
			sel_hram: cpu_rdata = hram_rdata;
			default:  cpu_rdata = open_bus;	// sb, unmapped
		endcase
	end

endmodule

//--- hdl/hram.sv
// 127 byte zero page ram at ff80-fffe, single port
// registered read, contents undefined after power up
module hram import gb_map_pkg::*; (
	input  logic       clk_cpu,
	input  io_sel_e    sel,
	input  logic       wr_q,
	input  bus_data_t  wdata_q,
	input  hram_addr_t hram_addr_q,
	output bus_data_t  hram_rdata
);

	bus_data_t mem [hram_depth];

	always_ff @(posedge clk_cpu) begin
		if (sel == sel_hram && wr_q)
			mem[hram_addr_q] <= wdata_q;
		// read every cycle, read_return picks it only for hram reads
		hram_rdata <= mem[hram_addr_q];
	end

endmodule

//--- hdl/irq_ctrl.sv
// interrupt flag and enable registers with the priority vector
// event strobes set IF at the end of their cycle, a cpu write of IF wins
// irq_ack clears the highest priority enabled flag in the same cycle
// irq_n and irq_vec are combinational from the registers
module irq_ctrl import gb_map_pkg::*, gb_irq_pkg::*; (
	input  logic      clk_cpu,
	input  logic      reset,
	input  io_sel_e   sel,
	input  logic      wr_q,
	input  bus_data_t wdata_q,
	input  logic      vblank_evt,
	input  logic      lcd_evt,
	input  logic      timer_evt,
	input  logic      serial_evt,
	input  logic      joy_edge,
	input  logic      irq_ack,
	output bus_data_t if_rdata,
	output bus_data_t ie_rdata,
	output logic      irq_n,
	output bus_data_t irq_vec
);

	irq_mask_t if_r, ie_r;
	irq_mask_t pending;
	irq_mask_t evt_mask;	// sources firing this cycle
	irq_mask_t ack_mask;	// lowest pending bit only
	irq_mask_t if_next;

	assign pending = if_r & ie_r;
	assign irq_n = ~|pending;

	always_comb begin
		evt_mask = '0;
		evt_mask[irq_vblank] = vblank_evt;
		evt_mask[irq_lcd]    = lcd_evt;
		evt_mask[irq_timer]  = timer_evt;
		evt_mask[irq_serial] = serial_evt;
		evt_mask[irq_joypad] = joy_edge;
	end

	// --------------------
	// priority, walk down so the lowest index is left last
	always_comb begin
		ack_mask = '0;
		irq_vec  = irq_vec_none;
		for (int i = irq_count - 1; i >= 0; i--) begin
			if (pending[i]) begin
				ack_mask    = '0;
				ack_mask[i] = 1'b1;
				irq_vec     = irq_vec_base + irq_vec_step * 8'(i);
			end
		end
	end

	always_comb begin
		if_next = if_r | evt_mask;
		if (irq_ack)
			if_next = if_next & ~ack_mask;
		if (sel == sel_if && wr_q)
			if_next = wdata_q[irq_count-1:0];	// cpu write has the last word
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r <= '0;
			ie_r <= '0;
		end else begin
			if_r <= if_next;
			if (sel == sel_ie && wr_q)
				ie_r <= wdata_q[irq_count-1:0];
		end
		if_rdata <= {{(8 - irq_count){1'b1}}, if_r};	// unused bits read high
		ie_rdata <= {{(8 - irq_count){1'b0}}, ie_r};
	end

endmodule

//--- hdl/serial_link.sv
// serial control register with a dummy transfer, no data is shifted
// a transfer needs SC bits 7 and 0 both set, external clock mode never ends
// length is about serial_bits * serial_bit_cycles clk_cpu cycles
// SB is not stored and reads open bus elsewhere
module serial_link import gb_map_pkg::*; (
	input  logic      clk_cpu,
	input  logic      reset,
	input  io_sel_e   sel,
	input  logic      wr_q,
	input  bus_data_t wdata_q,
	output bus_data_t sc_rdata,
	output logic      serial_evt
);

	logic     sc_start;	// SC bit 7, transfer busy
	logic     sc_clk;	// SC bit 0, internal clock
	ser_div_t div_cnt;	// cycles left in current bit
	ser_cnt_t bit_cnt;	// bits left

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			serial_evt <= 1'b0;
		end else begin
			serial_evt <= 1'b0;	// one cycle pulse
			if (sel == sel_sc && wr_q) begin
				sc_start <= wdata_q[7];
				sc_clk   <= wdata_q[0];
				if (wdata_q[7]) begin	// (re)start
					div_cnt <= ser_div_t'(serial_bit_cycles - 1);
					bit_cnt <= ser_cnt_t'(serial_bits);
				end
			end else if (sc_start && sc_clk) begin
				// --------------------
				// running transfer
				div_cnt <= div_cnt - ser_div_t'(1);	// wraps to full count
				if (div_cnt == '0 && bit_cnt != '0)
					bit_cnt <= bit_cnt - ser_cnt_t'(1);
				if (bit_cnt == '0) begin
					serial_evt <= 1'b1;
					sc_start   <= 1'b0;	// done, busy bit drops
				end
			end
		end
		sc_rdata <= {sc_start, 6'h3f, sc_clk};
	end

endmodule

//--- hdl/joypad_port.sv
// P1 joypad register with its two group select bits
// joystick is active high and unsynchronized, the edge history also syncs it
// a group that is deselected reads as all ones
module joypad_port import gb_map_pkg::*; (
	input  logic      clk_cpu,
	input  logic      reset,
	input  io_sel_e   sel,
	input  logic      wr_q,
	input  bus_data_t wdata_q,
	input  bus_data_t joystick,
	output bus_data_t joy_rdata,
	output logic      joy_edge
);

	logic [1:0] p54;		// P1 bits 5:4, low enables a group
	logic [3:0] dir_n, btn_n;	// active low groups
	logic [7:0] hist1, hist2;

	assign dir_n = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign btn_n = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54      <= 2'b00;
			hist1    <= 8'hff;	// idle lines, no edge after reset
			hist2    <= 8'hff;
			joy_edge <= 1'b0;
		end else begin
			if (sel == sel_joy && wr_q)
				p54 <= wdata_q[5:4];
			hist1    <= {dir_n, btn_n};
			hist2    <= hist1;
			joy_edge <= |(hist2 & ~hist1);	// any falling line
		end
		joy_rdata <= {2'b11, p54, dir_n & btn_n};	// stage 2 read byte
	end

endmodule

//--- hdl/io_decode.sv
// first pipeline stage, classifies the bus address and registers the request
// cpu_wr and cpu_rd are single cycle strobes, never both in one cycle
// ffff is the IE register even though it sits at the top of the hram page
module io_decode import gb_map_pkg::*; (
	input  logic       clk_cpu,
	input  logic       reset,
	input  bus_addr_t  cpu_addr,
	input  bus_data_t  cpu_wdata,
	input  logic       cpu_wr,
	input  logic       cpu_rd,
	output io_sel_e    sel,
	output logic       wr_q,
	output logic       rd_q,
	output bus_data_t  wdata_q,
	output hram_addr_t hram_addr_q
);

	io_sel_e sel_d;

	// address classification
	always_comb begin
		if (cpu_addr == addr_ie)
			sel_d = sel_ie;	// checked before the hram window
		else if (cpu_addr[15:7] == hram_base[15:7])
			sel_d = sel_hram;
		else begin
			case (cpu_addr)
				addr_joy: sel_d = sel_joy;
				addr_sb:  sel_d = sel_sb;
				addr_sc:  sel_d = sel_sc;
				addr_if:  sel_d = sel_if;
				default:  sel_d = sel_none;
			endcase
		end
	end

	// --------------------
	// request register
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sel  <= sel_none;
			wr_q <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			sel  <= (cpu_wr || cpu_rd) ? sel_d : sel_none;	// idle cycles target nothing
			wr_q <= cpu_wr;
			rd_q <= cpu_rd;
		end
		wdata_q     <= cpu_wdata;	// payload, qualified by wr_q
		hram_addr_q <= cpu_addr[6:0];
	end

endmodule

//--- hdl/gb_irq_pkg.sv
// interrupt sources, their flag bit positions and the rst vectors
// lower index means higher priority
// vector values are the 8 bit jump targets seen by the cpu on an ack
package gb_irq_pkg;

	localparam int irq_count = 5;	// five sources
	typedef logic [irq_count-1:0] irq_mask_t;

	// flag / enable bit positions
	localparam int irq_vblank = 0;
	localparam int irq_lcd    = 1;
	localparam int irq_timer  = 2;
	localparam int irq_serial = 3;
	localparam int irq_joypad = 4;

	// vector = base + step * index
	localparam logic [7:0] irq_vec_base = 8'h40;
	localparam logic [7:0] irq_vec_step = 8'h08;
	localparam logic [7:0] irq_vec_none = 8'h55;	// nothing pending

endpackage

//--- hdl/gb_map_pkg.sv
// register map of the io block, bus widths and the access select
// only the io page ff00-ffff is decoded, anything else reads open bus
// serial timing counts clk_cpu cycles, no separate shift clock exists
package gb_map_pkg;

	typedef logic [15:0] bus_addr_t;	// cpu address
	typedef logic [7:0]  bus_data_t;	// cpu data byte
	typedef logic [6:0]  hram_addr_t;	// zero page offset

	// target of a registered access
	typedef enum logic [2:0] {
		sel_none,
		sel_joy,
		sel_sb,
		sel_sc,
		sel_if,
		sel_ie,
		sel_hram
	} io_sel_e;

	localparam bus_addr_t addr_joy  = 16'hff00;	// P1
	localparam bus_addr_t addr_sb   = 16'hff01;	// serial data, not stored
	localparam bus_addr_t addr_sc   = 16'hff02;	// serial control
	localparam bus_addr_t addr_if   = 16'hff0f;
	localparam bus_addr_t addr_ie   = 16'hffff;
	localparam bus_addr_t hram_base = 16'hff80;
	localparam int hram_depth = 127;		// ff80..fffe

	// dummy serial transfer
	localparam int serial_bit_cycles = 512;
	localparam int serial_bits = 8;
	typedef logic [$clog2(serial_bit_cycles)-1:0] ser_div_t;
	typedef logic [$clog2(serial_bits+1)-1:0]     ser_cnt_t;

	localparam bus_data_t open_bus = 8'hff;	// unmapped read value

endpackage
